/* common/mips_settings.svh */
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// First fetch address after reset
`define MIPS_RESET_VECTOR 32'h0000_0010

// Architectural register count
`define MIPS_NUM_REGS 32

`endif

/* common/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    localparam opcode_t OP_RTYPE = 6'b000000;
    localparam opcode_t OP_J     = 6'b000010;
    localparam opcode_t OP_BEQ   = 6'b000100;
    localparam opcode_t OP_BNE   = 6'b000101;
    localparam opcode_t OP_ADDIU = 6'b001001;
    localparam opcode_t OP_SLTI  = 6'b001010;
    localparam opcode_t OP_ORI   = 6'b001101;
    localparam opcode_t OP_LW    = 6'b100011;
    localparam opcode_t OP_SW    = 6'b101011;

    localparam funct_t FN_JR   = 6'b001000;
    localparam funct_t FN_ADDU = 6'b100001;
    localparam funct_t FN_SUBU = 6'b100011;
    localparam funct_t FN_AND  = 6'b100100;
    localparam funct_t FN_OR   = 6'b100101;
    localparam funct_t FN_XOR  = 6'b100110;
    localparam funct_t FN_SLT  = 6'b101010;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_EQ, ALU_NE
    } alu_op_e;

    typedef enum logic [2:0] {
        ST_FETCH, ST_DECODE, ST_EXECUTE, ST_MEMORY, ST_STOPPED
    } ctrl_state_e;

    typedef enum logic [1:0] {
        CLASS_OTHER, CLASS_STORE, CLASS_LOAD
    } instr_class_e;

    typedef struct packed {
        logic       ir_write;
        logic       pc_write;
        logic       pc_branch;   // PC write when ALU flag set
        logic       reg_write;
        logic       iod;         // Address from ALU instead of pc
        logic       reg_dst_rd;
        logic       mem_to_reg;
        logic       alu_src_a;   // 0 pc, 1 A
        logic [1:0] alu_src_b;   // B, 4, imm, branch offset
        logic [1:0] pc_src;      // ALU, target reg, jump, A
        alu_op_e    alu_op;
    } ctrl_t;

    typedef struct packed {
        word_t address;
        logic  read;
        logic  write;
        word_t writedata;
    } mem_req_t;

endpackage

`default_nettype wire

/* cpu/mips_alu.sv */
`timescale 1ns/10ps
`default_nettype none

module mips_alu import mips_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  alu_op_e op,
    output word_t   result,
    output logic    flag
);

    logic equal;
    logic less;

    assign equal = (a == b);
    assign less  = ($signed(a) < $signed(b));

    // Branch condition
    assign flag = (op == ALU_NE) ? !equal : equal;

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLT: result = {31'd0, less};
            default: result = {31'd0, flag}; // EQ and NE
        endcase
    end

endmodule

`default_nettype wire

/* cpu/mips_regfile.sv */
`timescale 1ns/10ps
`default_nettype none
`include "mips_settings.svh"

module mips_regfile import mips_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      write_en,
    input  reg_addr_t read_addr_a,
    input  reg_addr_t read_addr_b,
    input  reg_addr_t write_addr,
    input  word_t     write_data,
    output word_t     read_data_a,
    output word_t     read_data_b,
    output word_t     register_v0
);

    word_t regs [`MIPS_NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && (write_addr != '0)) begin // r0 stays zero
            regs[write_addr] <= write_data;
        end
    end

    assign read_data_a = regs[read_addr_a];
    assign read_data_b = regs[read_addr_b];
    assign register_v0 = regs[2];

endmodule

`default_nettype wire

/* cpu/mips_datapath.sv */
`timescale 1ns/10ps
`default_nettype none
`include "mips_settings.svh"

module mips_datapath import mips_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  ctrl_t   ctrl,
    input  word_t   readdata,
    input  logic    waitrequest,
    output opcode_t opcode,
    output funct_t  funct,
    output word_t   pc,
    output word_t   address,
    output word_t   writedata,
    output word_t   register_v0
);

    word_t     ir;
    word_t     data_reg;
    word_t     a_reg;
    word_t     b_reg;
    word_t     alu_out;
    word_t     read_a;
    word_t     read_b;
    word_t     imm_ext;
    word_t     branch_off;
    word_t     jump_target;
    word_t     alu_a;
    word_t     alu_b;
    word_t     alu_y;
    word_t     pc_next;
    word_t     write_data;
    reg_addr_t write_addr;
    logic      alu_flag;
    logic      pc_en;

    assign opcode = ir[31:26];
    assign funct  = ir[5:0];

    // ORI is the only zero-extended immediate
    assign imm_ext     = (opcode == OP_ORI) ? {16'h0000, ir[15:0]} : {{16{ir[15]}}, ir[15:0]};
    assign branch_off  = {{14{ir[15]}}, ir[15:0], 2'b00};
    assign jump_target = {pc[31:28], ir[25:0], 2'b00};

    assign alu_a = ctrl.alu_src_a ? a_reg : pc;

    always_comb begin
        case (ctrl.alu_src_b)
            2'd0:    alu_b = b_reg;
            2'd1:    alu_b = 32'd4;
            2'd2:    alu_b = imm_ext;
            default: alu_b = branch_off;
        endcase
    end

    always_comb begin
        case (ctrl.pc_src)
            2'd0:    pc_next = alu_y;   // pc + 4 in fetch
            2'd1:    pc_next = alu_out; // Branch target from decode
            2'd2:    pc_next = jump_target;
            default: pc_next = a_reg;
        endcase
    end

    assign pc_en      = ctrl.pc_write || (ctrl.pc_branch && alu_flag);
    assign address    = ctrl.iod ? alu_y : pc;
    assign writedata  = b_reg;
    assign write_addr = ctrl.reg_dst_rd ? ir[15:11] : ir[20:16];
    assign write_data = ctrl.mem_to_reg ? data_reg : alu_y;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `MIPS_RESET_VECTOR;
        end else if (pc_en) begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.ir_write) begin
            ir <= readdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!waitrequest) begin // Frozen while an access is stretched
            data_reg <= readdata;
            a_reg    <= read_a;
            b_reg    <= read_b;
            alu_out  <= alu_y;
        end
    end

    mips_alu alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (ctrl.alu_op),
        .result (alu_y),
        .flag   (alu_flag)
    );

    mips_regfile regfile (
        .clk         (clk),
        .reset       (reset),
        .write_en    (ctrl.reg_write),
        .read_addr_a (ir[25:21]),
        .read_addr_b (ir[20:16]),
        .write_addr  (write_addr),
        .write_data  (write_data),
        .read_data_a (read_a),
        .read_data_b (read_b),
        .register_v0 (register_v0)
    );

endmodule

`default_nettype wire

/* cpu/mips_control.sv */
`timescale 1ns/10ps
`default_nettype none

module mips_control import mips_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    waitrequest,
    input  opcode_t opcode,
    input  funct_t  funct,
    input  word_t   pc,
    output ctrl_t   ctrl,
    output logic    mem_read,
    output logic    mem_write,
    output logic    active
);

    ctrl_state_e  state;
    ctrl_state_e  state_next;
    instr_class_e instr_class;
    logic         go;
    logic         pc_zero;

    assign go      = !waitrequest;
    assign pc_zero = (pc == '0);
    assign active  = (state != ST_STOPPED);

    always_comb begin
        case (opcode)
            OP_LW:   instr_class = CLASS_LOAD;
            OP_SW:   instr_class = CLASS_STORE;
            default: instr_class = CLASS_OTHER;
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_FETCH: begin
                if (pc_zero) begin
                    state_next = ST_STOPPED; // Jump to 0 ends the program
                end else if (go) begin
                    state_next = ST_DECODE;
                end
            end
            ST_DECODE: begin
                if (go) begin
                    state_next = ST_EXECUTE;
                end
            end
            ST_EXECUTE: begin
                if (go) begin
                    state_next = (instr_class == CLASS_LOAD) ? ST_MEMORY : ST_FETCH;
                end
            end
            ST_MEMORY: begin
                if (go) begin
                    state_next = ST_FETCH;
                end
            end
            default: state_next = ST_STOPPED; // Only reset leaves
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_FETCH;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ALU_ADD;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        case (state)
            ST_FETCH: begin
                mem_read       = !pc_zero;
                ctrl.ir_write  = go && !pc_zero;
                ctrl.pc_write  = go && !pc_zero;
                ctrl.alu_src_b = 2'd1; // pc + 4
            end
            ST_DECODE: begin
                ctrl.alu_src_b = 2'd3; // Branch target into ALU result reg
            end
            ST_EXECUTE: begin
                ctrl.alu_src_a = 1'b1;
                mem_read       = (instr_class == CLASS_LOAD);
                mem_write      = (instr_class == CLASS_STORE);
                case (opcode)
                    OP_RTYPE: begin
                        ctrl.reg_dst_rd = 1'b1;
                        ctrl.reg_write  = go;
                        case (funct)
                            FN_ADDU: ctrl.alu_op = ALU_ADD;
                            FN_SUBU: ctrl.alu_op = ALU_SUB;
                            FN_AND:  ctrl.alu_op = ALU_AND;
                            FN_OR:   ctrl.alu_op = ALU_OR;
                            FN_XOR:  ctrl.alu_op = ALU_XOR;
                            FN_SLT:  ctrl.alu_op = ALU_SLT;
                            FN_JR: begin
                                ctrl.reg_write = 1'b0;
                                ctrl.pc_write  = go;
                                ctrl.pc_src    = 2'd3;
                            end
                            default: ctrl.reg_write = 1'b0;
                        endcase
                    end
                    OP_ADDIU: begin
                        ctrl.alu_src_b = 2'd2;
                        ctrl.reg_write = go;
                    end
                    OP_ORI: begin
                        ctrl.alu_op    = ALU_OR;
                        ctrl.alu_src_b = 2'd2;
                        ctrl.reg_write = go;
                    end
                    OP_SLTI: begin
                        ctrl.alu_op    = ALU_SLT;
                        ctrl.alu_src_b = 2'd2;
                        ctrl.reg_write = go;
                    end
                    OP_LW, OP_SW: begin
                        ctrl.alu_src_b = 2'd2; // Base plus offset
                        ctrl.iod       = 1'b1;
                    end
                    OP_BEQ, OP_BNE: begin
                        ctrl.alu_op    = (opcode == OP_BEQ) ? ALU_EQ : ALU_NE;
                        ctrl.pc_branch = go;
                        ctrl.pc_src    = 2'd1;
                    end
                    OP_J: begin
                        ctrl.pc_write = go;
                        ctrl.pc_src   = 2'd2;
                    end
                    default: ctrl.alu_src_a = 1'b1;
                endcase
            end
            ST_MEMORY: begin
                ctrl.reg_write  = go;
                ctrl.mem_to_reg = 1'b1; // Load data from data register
            end
            default: ctrl.alu_op = ALU_ADD;
        endcase
    end

endmodule

`default_nettype wire

/* design/mips_cpu.sv */
`timescale 1ns/10ps
`default_nettype none

module mips_cpu import mips_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     waitrequest,
    input  word_t    readdata,
    output mem_req_t mem_req,
    output logic     active,
    output word_t    register_v0
);

    ctrl_t   ctrl;
    opcode_t opcode;
    funct_t  funct;
    word_t   pc;
    word_t   address;
    word_t   writedata;
    logic    mem_read;
    logic    mem_write;

    assign mem_req = '{address: address, read: mem_read, write: mem_write, writedata: writedata};

    mips_control control (
        .clk         (clk),
        .reset       (reset),
        .waitrequest (waitrequest),
        .opcode      (opcode),
        .funct       (funct),
        .pc          (pc),
        .ctrl        (ctrl),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .active      (active)
    );

    mips_datapath datapath (
        .clk         (clk),
        .reset       (reset),
        .ctrl        (ctrl),
        .readdata    (readdata),
        .waitrequest (waitrequest),
        .opcode      (opcode),
        .funct       (funct),
        .pc          (pc),
        .address     (address),
        .writedata   (writedata),
        .register_v0 (register_v0)
    );

endmodule

`default_nettype wire

/* testbench/mips_mem_model.sv */
`timescale 1ns/10ps
`default_nettype none

module mips_mem_model import mips_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  mem_req_t   mem_req,
    input  logic       random_waits,
    input  logic [1:0] wait_draw,
    output logic       waitrequest,
    output word_t      readdata
);

    localparam int DEPTH = 1024;

    word_t      words [DEPTH];
    logic [1:0] waited;
    logic [1:0] wait_len;
    logic       access;

    assign access      = mem_req.read || mem_req.write;
    assign waitrequest = access && (waited != wait_len);
    assign readdata    = words[mem_req.address[11:2]];

    always @(posedge clk) begin
        if (reset) begin
            waited   <= 2'd0;
            wait_len <= random_waits ? wait_draw : 2'd0;
        end else if (access && waitrequest) begin
            waited <= waited + 2'd1;
        end else if (access) begin // Access completes
            waited   <= 2'd0;
            wait_len <= random_waits ? wait_draw : 2'd0;
            if (mem_req.write) begin
                words[mem_req.address[11:2]] <= mem_req.writedata;
            end
        end
    end

    task automatic fill();
        for (int i = 0; i < DEPTH; i++) begin
            words[i] = 32'h5a5a_0000 ^ word_t'(i * 4);
        end
    endtask

    task automatic write_word(input word_t addr, input word_t data);
        words[addr[11:2]] = data;
    endtask

    function automatic word_t read_word(input word_t addr);
        return words[addr[11:2]];
    endfunction

endmodule

`default_nettype wire

/* testbench/mips_cpu_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module mips_cpu_assert import mips_pkg::*; (
    input logic        clk,
    input logic        reset,
    input logic        waitrequest,
    input logic        mem_read,
    input logic        mem_write,
    input logic        active,
    input word_t       pc,
    input ctrl_state_e state
);

    int error_count = 0;

    bus_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(mem_read && mem_write))
    else begin
        error_count = error_count + 1;
        $error("Read and write strobes high together");
    end

    // Stretched access keeps strobes, fetch address and state
    bus_stable: assert property (@(posedge clk) disable iff (reset)
        (mem_read || mem_write) && waitrequest |=>
            $stable(mem_read) && $stable(mem_write) && $stable(pc) && $stable(state))
    else begin
        error_count = error_count + 1;
        $error("Bus request changed while waitrequest was high");
    end

    halt_sticky: assert property (@(posedge clk) disable iff (reset)
        !active |=> !active)
    else begin
        error_count = error_count + 1;
        $error("Active rose again without reset");
    end

endmodule

`default_nettype wire

/* testbench/mips_cpu_tb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "mips_settings.svh"

module mips_cpu_tb import mips_pkg::*; ();

    localparam int INSTRS_PER_TEST  = 40;
    localparam int CYCLES_PER_INSTR = 10; // Four states, two accesses stretched by 3
    localparam int HALT_LIMIT       = INSTRS_PER_TEST * CYCLES_PER_INSTR;
    localparam int WATCHDOG_CYCLES  = 40 * (HALT_LIMIT + 30);

    logic        clk = 1'b0;
    logic        reset;
    logic        waitrequest;
    word_t       readdata;
    mem_req_t    mem_req;
    logic        active;
    word_t       register_v0;
    logic        random_waits;
    logic [1:0]  wait_draw;
    word_t       lcg_state = 32'hbb3b_6a96;
    logic [15:0] imm_a;
    logic [15:0] imm_b;
    logic [15:0] imm_c;
    logic [15:0] imm_d;
    word_t       preload;
    word_t       prog [$];

    always #5 clk = ~clk;

    mips_cpu dut (
        .clk         (clk),
        .reset       (reset),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .mem_req     (mem_req),
        .active      (active),
        .register_v0 (register_v0)
    );

    mips_mem_model memory (
        .clk          (clk),
        .reset        (reset),
        .mem_req      (mem_req),
        .random_waits (random_waits),
        .wait_draw    (wait_draw),
        .waitrequest  (waitrequest),
        .readdata     (readdata)
    );

    bind mips_control mips_cpu_assert assertions (
        .clk         (clk),
        .reset       (reset),
        .waitrequest (waitrequest),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .active      (active),
        .pc          (pc),
        .state       (state)
    );

    function automatic word_t lcg_draw();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    always @(posedge clk) begin
        wait_draw <= 2'(lcg_draw() >> 30);
    end

    function automatic word_t enc_r(funct_t fn, reg_addr_t rd, reg_addr_t rs, reg_addr_t rt);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t enc_i(opcode_t op, reg_addr_t rt, reg_addr_t rs, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t enc_j(word_t target);
        return {OP_J, target[27:2]};
    endfunction

    function automatic word_t sext(logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            fail_now($sformatf("CHECK FAILED %s: got %h, expected %h", name, actual, expected));
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            fail_now($sformatf("CHECK FAILED %s: got %h, expected %h", name, actual, expected));
        end
    endtask

    task automatic load_program();
        memory.fill();
        foreach (prog[i]) begin
            memory.write_word(word_t'(`MIPS_RESET_VECTOR + 4 * i), prog[i]);
        end
        prog.delete();
    endtask

    // Reset for 3 cycles, then the first fetch must show up right away
    task automatic start_program(input logic use_waits);
        @(posedge clk);
        random_waits <= use_waits;
        reset        <= 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_flag("active", active, 1'b1);
        check_flag("mem_req.read", mem_req.read, 1'b1);
        check_word("mem_req.address", mem_req.address, `MIPS_RESET_VECTOR);
    endtask

    task automatic wait_for_halt();
        int cycles;
        cycles = 0;
        while (active !== 1'b0) begin
            @(negedge clk);
            cycles++;
            if (cycles > HALT_LIMIT) begin
                fail_now("The core did not halt within the cycle limit");
            end
        end
    endtask

    task automatic test_alu(input logic use_waits);
        word_t r8, r9, r10, r11, r14, r15, r16, r17;
        r8  = sext(imm_a);
        r9  = sext(imm_b);
        r10 = r8 + r9;
        r11 = r8 - r9;
        r14 = ((r10 & r11) | r9) ^ r8;
        r15 = r14 | {16'h0000, imm_c};
        r16 = ($signed(r8) < $signed(r9)) ? 32'd1 : 32'd0;
        r17 = ($signed(r11) < $signed(sext(imm_d))) ? 32'd1 : 32'd0;
        prog.push_back(enc_i(OP_ADDIU, 5'd8, 5'd0, imm_a));
        prog.push_back(enc_i(OP_ADDIU, 5'd9, 5'd0, imm_b));
        prog.push_back(enc_r(FN_ADDU, 5'd10, 5'd8, 5'd9));
        prog.push_back(enc_r(FN_SUBU, 5'd11, 5'd8, 5'd9));
        prog.push_back(enc_r(FN_AND, 5'd12, 5'd10, 5'd11));
        prog.push_back(enc_r(FN_OR, 5'd13, 5'd12, 5'd9));
        prog.push_back(enc_r(FN_XOR, 5'd14, 5'd13, 5'd8));
        prog.push_back(enc_i(OP_ORI, 5'd15, 5'd14, imm_c));
        prog.push_back(enc_r(FN_SLT, 5'd16, 5'd8, 5'd9));
        prog.push_back(enc_i(OP_SLTI, 5'd17, 5'd11, imm_d));
        prog.push_back(enc_r(FN_ADDU, 5'd0, 5'd8, 5'd9)); // r0 must stay zero
        prog.push_back(enc_r(FN_ADDU, 5'd18, 5'd15, 5'd16));
        prog.push_back(enc_r(FN_ADDU, 5'd18, 5'd18, 5'd17));
        prog.push_back(enc_r(FN_ADDU, 5'd2, 5'd18, 5'd0));
        prog.push_back(enc_i(OP_SW, 5'd10, 5'd0, 16'h0200));
        prog.push_back(enc_i(OP_SW, 5'd14, 5'd0, 16'h0204));
        prog.push_back(enc_i(OP_SW, 5'd0, 5'd0, 16'h0208));
        prog.push_back(enc_j(32'h0));
        load_program();
        start_program(use_waits);
        wait_for_halt();
        check_word("register_v0", register_v0, r15 + r16 + r17);
        check_word("mem[0x200]", memory.read_word(32'h200), r10);
        check_word("mem[0x204]", memory.read_word(32'h204), r14);
        check_word("mem[0x208]", memory.read_word(32'h208), 32'h0);
    endtask

    task automatic test_load_store();
        word_t r8, r9;
        r8 = sext(imm_b);
        r9 = {16'h0000, imm_c};
        prog.push_back(enc_i(OP_ADDIU, 5'd8, 5'd0, imm_b));
        prog.push_back(enc_i(OP_ORI, 5'd9, 5'd0, imm_c));
        prog.push_back(enc_r(FN_ADDU, 5'd10, 5'd8, 5'd9));
        prog.push_back(enc_i(OP_ADDIU, 5'd20, 5'd0, 16'h0300)); // Base address
        prog.push_back(enc_i(OP_SW, 5'd8, 5'd20, 16'h0000));
        prog.push_back(enc_i(OP_SW, 5'd10, 5'd20, 16'h0004));
        prog.push_back(enc_i(OP_SW, 5'd9, 5'd20, 16'hfffc));
        prog.push_back(enc_i(OP_LW, 5'd11, 5'd20, 16'h0004));
        prog.push_back(enc_i(OP_LW, 5'd12, 5'd20, 16'h0000));
        prog.push_back(enc_i(OP_LW, 5'd13, 5'd20, 16'hfffc));
        prog.push_back(enc_i(OP_LW, 5'd16, 5'd20, 16'h0010));
        prog.push_back(enc_r(FN_ADDU, 5'd15, 5'd11, 5'd12));
        prog.push_back(enc_r(FN_ADDU, 5'd15, 5'd15, 5'd13));
        prog.push_back(enc_r(FN_ADDU, 5'd2, 5'd15, 5'd16));
        prog.push_back(enc_j(32'h0));
        load_program();
        memory.write_word(32'h310, preload);
        start_program(1'b1);
        wait_for_halt();
        check_word("mem[0x300]", memory.read_word(32'h300), r8);
        check_word("mem[0x304]", memory.read_word(32'h304), r8 + r9);
        check_word("mem[0x2fc]", memory.read_word(32'h2fc), r9);
        check_word("register_v0", register_v0, (r8 + r9) + r8 + r9 + preload);
    endtask

    // Skipped instructions add large values, so any wrong path shows in v0
    task automatic test_flow();
        prog.push_back(enc_i(OP_ADDIU, 5'd2, 5'd0, 16'd1));     // 0x10
        prog.push_back(enc_i(OP_ADDIU, 5'd8, 5'd0, 16'd5));
        prog.push_back(enc_i(OP_ADDIU, 5'd9, 5'd0, 16'd5));
        prog.push_back(enc_i(OP_BEQ, 5'd9, 5'd8, 16'd1));      // 0x1c taken
        prog.push_back(enc_i(OP_ADDIU, 5'd2, 5'd2, 16'd100));
        prog.push_back(enc_i(OP_BNE, 5'd9, 5'd8, 16'd1));      // 0x24 not taken
        prog.push_back(enc_i(OP_ADDIU, 5'd2, 5'd2, 16'd2));
        prog.push_back(enc_i(OP_ADDIU, 5'd9, 5'd0, 16'd7));
        prog.push_back(enc_i(OP_BEQ, 5'd9, 5'd8, 16'd1));      // 0x30 not taken
        prog.push_back(enc_i(OP_ADDIU, 5'd2, 5'd2, 16'd4));
        prog.push_back(enc_i(OP_BNE, 5'd9, 5'd8, 16'd1));      // 0x38 taken
        prog.push_back(enc_i(OP_ADDIU, 5'd2, 5'd2, 16'd200));
        prog.push_back(enc_j(32'h4c));                         // 0x40
        prog.push_back(enc_i(OP_ADDIU, 5'd2, 5'd2, 16'd400));
        prog.push_back(enc_i(OP_ADDIU, 5'd2, 5'd2, 16'd800));
        prog.push_back(enc_i(OP_ADDIU, 5'd10, 5'd0, 16'h005c)); // 0x4c
        prog.push_back(enc_r(FN_JR, 5'd0, 5'd10, 5'd0));
        prog.push_back(enc_i(OP_ADDIU, 5'd2, 5'd2, 16'd1000));
        prog.push_back(enc_i(OP_ADDIU, 5'd2, 5'd2, 16'd2000));
        prog.push_back(enc_i(OP_ADDIU, 5'd2, 5'd2, 16'd8));    // 0x5c
        prog.push_back(enc_i(OP_ADDIU, 5'd11, 5'd0, 16'd3));
        prog.push_back(enc_i(OP_ADDIU, 5'd2, 5'd2, 16'd16));   // 0x64 loop body
        prog.push_back(enc_i(OP_ADDIU, 5'd11, 5'd11, 16'hffff));
        prog.push_back(enc_i(OP_BNE, 5'd0, 5'd11, 16'hfffd));  // Back to 0x64
        prog.push_back(enc_j(32'h0));
        load_program();
        start_program(1'b1);
        wait_for_halt();
        check_word("register_v0", register_v0, 32'd1 + 32'd2 + 32'd4 + 32'd8 + 32'd3 * 32'd16);
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_flag("active", active, 1'b0);
            check_flag("mem_req.read", mem_req.read, 1'b0);
            check_flag("mem_req.write", mem_req.write, 1'b0);
        end
    endtask

    // Program from test_flow is still in memory
    task automatic test_reset();
        start_program(1'b0);
        wait_for_halt();
        check_word("register_v0", register_v0, 32'd63);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_now("Watchdog timeout, the tests did not finish in time");
    end

    initial begin
        reset        = 1'b1;
        random_waits = 1'b0;
        wait_draw    = 2'd0;
        imm_a        = 16'(lcg_draw() >> 16);
        imm_b        = 16'(lcg_draw() >> 16);
        imm_c        = 16'(lcg_draw() >> 16);
        imm_d        = 16'(lcg_draw() >> 16);
        preload      = lcg_draw();
        test_alu(1'b0);
        test_alu(1'b1);
        test_load_store();
        test_flow();
        check_idle(20);
        test_reset();
        if (dut.control.assertions.error_count != 0) begin
            fail_now("The bound assertions reported errors");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* mips_cpu.f */
+incdir+common
common/mips_pkg.sv
cpu/mips_alu.sv
cpu/mips_regfile.sv
cpu/mips_datapath.sv
cpu/mips_control.sv
design/mips_cpu.sv
testbench/mips_mem_model.sv
testbench/mips_cpu_assert.sv
testbench/mips_cpu_tb.sv

/* Bender.yml */
package:
  name: mips_cpu

sources:
  - include_dirs:
      - common
    files:
      - common/mips_pkg.sv
      - cpu/mips_alu.sv
      - cpu/mips_regfile.sv
      - cpu/mips_datapath.sv
      - cpu/mips_control.sv
      - design/mips_cpu.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/mips_mem_model.sv
      - testbench/mips_cpu_assert.sv
      - testbench/mips_cpu_tb.sv
